// ==== common/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// 32-bit words in the RAM
`define MEM_WORDS 1024

// transmit queue entries, power of two
`define TXQ_DEPTH 16

// byte address of the transmit queue
// lies above the RAM so it never aliases a word
`define MMIO_TXQ_ADDR 32'h0000_F000

`endif

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

    typedef logic [31:0] word_t;   // data word
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] wmask_t;  // one bit per data bit

    // arbiter FSM
    typedef enum logic [1:0] {
        arb_idle,
        arb_wait_ready,            // command held until the bus is free
        arb_wait_read
    } arb_state_t;

    // misaligned access FSM in the controller
    typedef enum logic [1:0] {
        split_idle,
        split_second,              // upper word on the RAM bus
        split_merge                // upper word returns, halves merged
    } split_state_t;

endpackage

// ==== common/mmio_pkg.sv ====
`include "mem_defines.svh"

package mmio_pkg;

    localparam int TXQ_PTR_W = $clog2(`TXQ_DEPTH);

    typedef logic [7:0]           txq_byte_t;
    typedef logic [TXQ_PTR_W-1:0] txq_ptr_t;
    typedef logic [TXQ_PTR_W:0]   txq_count_t;  // holds 0 to TXQ_DEPTH

endpackage

// ==== mem_if/mem_arbiter.sv ====
module mem_arbiter import mem_bus_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   halt,
    input  logic   inst_start,
    input  addr_t  i_addr,
    output logic   inst_ready,
    output word_t  inst,
    output logic   inst_valid,
    input  logic   d_cmd_start,
    input  logic   d_cmd_write,
    input  addr_t  d_addr,
    input  word_t  wdata,
    input  wmask_t wmask,
    output logic   d_cmd_ready,
    output word_t  rdata,
    output logic   rdata_valid,
    output logic   cmd_start,
    output logic   cmd_write,
    output addr_t  cmd_addr,
    output word_t  cmd_wdata,
    output wmask_t cmd_wmask,
    input  logic   cmd_ready,
    input  word_t  rsp_data,
    input  logic   rsp_valid
);

    arb_state_t state;
    logic       cmd_is_inst;   // held or outstanding command is the fetch
    logic       save_d_start;  // data command not issued yet
    logic       save_d_write;
    addr_t      save_i_addr;
    addr_t      save_d_addr;
    word_t      save_wdata;
    wmask_t     save_wmask;
    word_t      last_inst;
    word_t      last_rdata;

    // split writes keep the controller busy one more cycle
    function automatic arb_state_t after_write(input addr_t addr);
        return (addr[1:0] != 2'b00) ? arb_wait_ready : arb_idle;
    endfunction

    assign inst_ready  = (state == arb_idle);
    assign d_cmd_ready = (state == arb_idle);
    assign inst_valid  = (state == arb_wait_read) && rsp_valid && cmd_is_inst;
    assign rdata_valid = (state == arb_wait_read) && rsp_valid && !cmd_is_inst;
    assign inst        = inst_valid ? rsp_data : last_inst;   // hold between pulses
    assign rdata       = rdata_valid ? rsp_data : last_rdata;

    // halt only blocks issue, accepted commands wait in arb_wait_ready
    always_comb begin
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = save_d_addr;
        cmd_wdata = save_wdata;
        cmd_wmask = save_wmask;
        case (state)
            arb_idle: begin
                cmd_start = !halt && cmd_ready && (inst_start || d_cmd_start);
                cmd_write = !inst_start && d_cmd_write;   // fetch goes first
                cmd_addr  = inst_start ? i_addr : d_addr;
                cmd_wdata = wdata;
                cmd_wmask = wmask;
            end
            arb_wait_ready: begin
                cmd_start = !halt && cmd_ready && (cmd_is_inst || save_d_start);
                cmd_write = !cmd_is_inst && save_d_write;
                cmd_addr  = cmd_is_inst ? save_i_addr : save_d_addr;
            end
            arb_wait_read: begin
                // saved data command follows the fetch response directly
                cmd_start = !halt && cmd_ready && rsp_valid && cmd_is_inst && save_d_start;
                cmd_write = save_d_write;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == arb_idle) begin
            save_i_addr  <= i_addr;
            save_d_write <= d_cmd_write;
            save_d_addr  <= d_addr;
            save_wdata   <= wdata;
            save_wmask   <= wmask;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= arb_idle;
            cmd_is_inst  <= 1'b0;
            save_d_start <= 1'b0;
            last_inst    <= '1;
            last_rdata   <= '1;
        end else begin
            case (state)
                arb_idle: begin
                    if (inst_start) begin
                        cmd_is_inst  <= 1'b1;
                        save_d_start <= d_cmd_start;
                        state        <= cmd_start ? arb_wait_read : arb_wait_ready;
                    end else if (d_cmd_start) begin
                        cmd_is_inst  <= 1'b0;
                        save_d_start <= !cmd_start;
                        if (!cmd_start) begin
                            state <= arb_wait_ready;
                        end else begin
                            state <= d_cmd_write ? after_write(d_addr) : arb_wait_read;
                        end
                    end
                end
                arb_wait_ready: begin
                    if (cmd_is_inst) begin
                        if (cmd_start) state <= arb_wait_read;
                    end else if (save_d_start) begin
                        if (cmd_start) begin
                            save_d_start <= 1'b0;
                            state <= save_d_write ? after_write(save_d_addr) : arb_wait_read;
                        end
                    end else begin
                        state <= arb_idle;   // upper half of a split write goes out now
                    end
                end
                arb_wait_read: begin
                    if (rsp_valid && cmd_is_inst) begin
                        last_inst   <= rsp_data;
                        cmd_is_inst <= 1'b0;
                        if (!save_d_start) begin
                            state <= arb_idle;
                        end else if (!cmd_start) begin
                            state <= arb_wait_ready;
                        end else begin
                            save_d_start <= 1'b0;
                            state <= save_d_write ? after_write(save_d_addr) : arb_wait_read;
                        end
                    end else if (rsp_valid) begin
                        last_rdata <= rsp_data;
                        state      <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule

// ==== mem_if/mem_access_ctrl.sv ====
`include "mem_defines.svh"

module mem_access_ctrl import mem_bus_pkg::*, mmio_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          cmd_start,
    input  logic                          cmd_write,
    input  addr_t                         cmd_addr,
    input  word_t                         cmd_wdata,
    input  wmask_t                        cmd_wmask,
    output logic                          cmd_ready,
    output word_t                         rsp_data,
    output logic                          rsp_valid,
    output logic                          ram_cmd_start,
    output logic                          ram_cmd_write,
    output logic [$clog2(`MEM_WORDS)-1:0] ram_word_addr,
    output word_t                         ram_wdata,
    output wmask_t                        ram_wmask,
    input  word_t                         ram_rdata,
    input  logic                          ram_rsp_valid,
    output logic                          push,
    output txq_byte_t                     push_data,
    input  txq_count_t                    txq_count
);

    localparam int WAW = $clog2(`MEM_WORDS);

    split_state_t   state;
    logic           split_read;
    logic           mmio_rsp;     // queue count answers next cycle
    logic [1:0]     offset;
    logic [WAW-1:0] hi_addr;
    word_t          hi_wdata;
    wmask_t         hi_wmask;
    word_t          lo_rdata;
    logic           is_mmio;
    logic           misaligned;
    logic [63:0]    wdata_pair;   // {upper word, lower word}
    logic [63:0]    wmask_pair;
    logic [63:0]    rdata_pair;

    assign is_mmio    = (cmd_addr == `MMIO_TXQ_ADDR);
    assign misaligned = (cmd_addr[1:0] != 2'b00) && !is_mmio;
    assign wdata_pair = {32'd0, cmd_wdata} << {cmd_addr[1:0], 3'b000};
    assign wmask_pair = {32'd0, cmd_wmask} << {cmd_addr[1:0], 3'b000};
    assign rdata_pair = {ram_rdata, lo_rdata} >> {offset, 3'b000};   // little endian

    assign cmd_ready = (state == split_idle);
    assign push      = cmd_ready && cmd_start && cmd_write && is_mmio;
    assign push_data = cmd_wdata[7:0];
    assign rsp_valid = mmio_rsp || (ram_rsp_valid && state != split_second);
    assign rsp_data  = mmio_rsp ? word_t'(txq_count) :
                       (state == split_merge) ? rdata_pair[31:0] : ram_rdata;

    always_comb begin
        if (state == split_second) begin
            ram_cmd_start = 1'b1;
            ram_cmd_write = !split_read;
            ram_word_addr = hi_addr;
            ram_wdata     = hi_wdata;
            ram_wmask     = hi_wmask;
        end else begin
            ram_cmd_start = cmd_start && cmd_ready && !is_mmio;
            ram_cmd_write = cmd_write;
            ram_word_addr = cmd_addr[WAW+1:2];
            ram_wdata     = wdata_pair[31:0];
            ram_wmask     = wmask_pair[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_start && misaligned) begin
            offset   <= cmd_addr[1:0];
            hi_addr  <= cmd_addr[WAW+1:2] + 1'b1;
            hi_wdata <= wdata_pair[63:32];
            hi_wmask <= wmask_pair[63:32];
        end
        if (state == split_second && split_read) lo_rdata <= ram_rdata;   // lower half
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= split_idle;
            split_read <= 1'b0;
            mmio_rsp   <= 1'b0;
        end else begin
            mmio_rsp <= cmd_ready && cmd_start && !cmd_write && is_mmio;
            case (state)
                split_idle: begin
                    if (cmd_start && misaligned) begin
                        state      <= split_second;
                        split_read <= !cmd_write;
                    end
                end
                split_second: state <= split_read ? split_merge : split_idle;
                default:      state <= split_idle;
            endcase
        end
    end

endmodule

// ==== mem_if/mem_array.sv ====
`include "mem_defines.svh"

module mem_array import mem_bus_pkg::*; (
    input  logic                          clk,
    input  logic                          ram_cmd_start,
    input  logic                          ram_cmd_write,
    input  logic [$clog2(`MEM_WORDS)-1:0] ram_word_addr,
    input  word_t                         ram_wdata,
    input  wmask_t                        ram_wmask,
    output word_t                         ram_rdata,
    output logic                          ram_rsp_valid
);

    word_t mem [`MEM_WORDS];
    logic  rd_req;
    logic  wr_req;
    word_t merged;   // old word with masked bits replaced

    assign rd_req = ram_cmd_start && !ram_cmd_write;
    assign wr_req = ram_cmd_start && ram_cmd_write;
    assign merged = (mem[ram_word_addr] & ~ram_wmask) | (ram_wdata & ram_wmask);

    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem[ram_word_addr] <= merged;
        end
    end

    // registered read, one cycle
    always_ff @(posedge clk) begin
        if (rd_req) begin
            ram_rdata <= mem[ram_word_addr];
        end
    end

    always_ff @(posedge clk) begin
        ram_rsp_valid <= rd_req;   // single cycle pulse per read
    end

endmodule

// ==== src/tx_queue.sv ====
`include "mem_defines.svh"

module tx_queue import mmio_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  txq_byte_t  push_data,
    input  logic       txq_pop,
    output txq_byte_t  txq_data,
    output logic       txq_empty,
    output txq_count_t txq_count
);

    txq_byte_t fifo_mem [`TXQ_DEPTH];
    txq_ptr_t  head;   // oldest entry
    txq_ptr_t  tail;   // next free slot
    logic      do_push;
    logic      do_pop;

    assign txq_empty = (txq_count == '0);
    assign txq_data  = fifo_mem[head];
    assign do_push   = push && (txq_count != txq_count_t'(`TXQ_DEPTH));   // full drops
    assign do_pop    = txq_pop && !txq_empty;

    always_ff @(posedge clk) begin
        if (do_push) fifo_mem[tail] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head      <= '0;
            tail      <= '0;
            txq_count <= '0;
        end else begin
            if (do_push) tail <= tail + 1'b1;   // wraps at depth
            if (do_pop)  head <= head + 1'b1;
            if (do_push && !do_pop) txq_count <= txq_count + 1'b1;
            else if (do_pop && !do_push) txq_count <= txq_count - 1'b1;
        end
    end

endmodule

// ==== src/mem_subsys_top.sv ====
`include "mem_defines.svh"

module mem_subsys_top import mem_bus_pkg::*, mmio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      halt,
    input  logic      inst_start,
    input  addr_t     i_addr,
    output logic      inst_ready,
    output word_t     inst,
    output logic      inst_valid,
    input  logic      d_cmd_start,
    input  logic      d_cmd_write,
    input  addr_t     d_addr,
    input  word_t     wdata,
    input  wmask_t    wmask,
    output logic      d_cmd_ready,
    output word_t     rdata,
    output logic      rdata_valid,
    output txq_byte_t txq_data,
    output logic      txq_empty,
    input  logic      txq_pop
);

    localparam int WAW = $clog2(`MEM_WORDS);

    logic           cmd_start, cmd_write, cmd_ready, rsp_valid;
    addr_t          cmd_addr;
    word_t          cmd_wdata, rsp_data;
    wmask_t         cmd_wmask;
    logic           ram_cmd_start, ram_cmd_write, ram_rsp_valid;
    logic [WAW-1:0] ram_word_addr;
    word_t          ram_wdata, ram_rdata;
    wmask_t         ram_wmask;
    logic           push;
    txq_byte_t      push_data;
    txq_count_t     txq_count;

    mem_arbiter u_arbiter (
        .clk, .arst_n, .halt,
        .inst_start, .i_addr, .inst_ready, .inst, .inst_valid,
        .d_cmd_start, .d_cmd_write, .d_addr, .wdata, .wmask,
        .d_cmd_ready, .rdata, .rdata_valid,
        .cmd_start, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_wmask,
        .cmd_ready, .rsp_data, .rsp_valid
    );

    mem_access_ctrl u_access_ctrl (
        .clk, .arst_n,
        .cmd_start, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_wmask,
        .cmd_ready, .rsp_data, .rsp_valid,
        .ram_cmd_start, .ram_cmd_write, .ram_word_addr, .ram_wdata, .ram_wmask,
        .ram_rdata, .ram_rsp_valid,
        .push, .push_data, .txq_count
    );

    mem_array u_array (
        .clk,
        .ram_cmd_start, .ram_cmd_write, .ram_word_addr, .ram_wdata, .ram_wmask,
        .ram_rdata, .ram_rsp_valid
    );

    tx_queue u_tx_queue (
        .clk, .arst_n,
        .push, .push_data, .txq_pop,
        .txq_data, .txq_empty, .txq_count
    );

endmodule

// ==== verif/mem_subsys_properties.sv ====
module mem_subsys_properties (
    input logic clk,
    input logic arst_n,
    input logic inst_valid,
    input logic rdata_valid,
    input logic inst_ready,
    input logic d_cmd_ready,
    input logic ram_rd,      // read command on the RAM bus
    input logic ram_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;   // failed assertions so far

    // one response per cycle towards the core
    assert property (@(posedge clk) disable iff (!arst_n) !(inst_valid && rdata_valid))
        else begin
            $error("inst_valid and rdata_valid high in the same cycle");
            fails++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) inst_ready == d_cmd_ready)
        else begin
            $error("inst_ready and d_cmd_ready differ");
            fails++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) ram_rd |=> ram_valid)
        else begin
            $error("ram_rsp_valid missing one cycle after a read");
            fails++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) !ram_rd |=> !ram_valid)
        else begin
            $error("ram_rsp_valid without a read one cycle before");
            fails++;
        end

endmodule

bind mem_arbiter mem_subsys_properties u_arb_props (
    .clk, .arst_n, .inst_valid, .rdata_valid, .inst_ready, .d_cmd_ready,
    .ram_rd(1'b0), .ram_valid(1'b0)
);

// read pipe of the array, live from the first clock edge
bind mem_array mem_subsys_properties u_array_props (
    .clk, .arst_n(1'b1), .inst_valid(1'b0), .rdata_valid(1'b0),
    .inst_ready(1'b1), .d_cmd_ready(1'b1),
    .ram_rd(ram_cmd_start && !ram_cmd_write), .ram_valid(ram_rsp_valid)
);

// ==== verif/mem_subsys_tb.sv ====
`include "mem_defines.svh"

module mem_subsys_tb import mem_bus_pkg::*, mmio_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT   = 50;   // cycles allowed per wait
    localparam int REGION    = 64;   // words written before any read
    localparam int SEL_INST  = 0;
    localparam int SEL_RDATA = 1;
    localparam int SEL_READY = 2;

    logic      clk, arst_n, halt;
    logic      inst_start, inst_ready, inst_valid;
    addr_t     i_addr;
    word_t     inst;
    logic      d_cmd_start, d_cmd_write, d_cmd_ready, rdata_valid;
    addr_t     d_addr;
    word_t     wdata, rdata;
    wmask_t    wmask;
    txq_byte_t txq_data;
    logic      txq_empty, txq_pop;

    logic [7:0]  ref_mem [4*`MEM_WORDS];   // little endian byte model
    logic [31:0] rng_state;
    int          cyc = 0;
    int          acc_cyc;                  // cycle of the last acceptance
    int          errors;
    int          timeouts;
    int          assert_fails;

    mem_subsys_top u_mem_subsys_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t model_read(input addr_t a);
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    task automatic model_write(input addr_t a, input word_t d, input wmask_t m);
        int i;
        for (i = 0; i < 32; i++) begin
            if (m[i]) ref_mem[a + i / 8][i % 8] = d[i];
        end
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    function automatic logic watched(input int sel);
        case (sel)
            SEL_INST:  return inst_valid;
            SEL_RDATA: return rdata_valid;
            default:   return d_cmd_ready;
        endcase
    endfunction

    // samples mid cycle and returns the cycles since acceptance
    task automatic wait_high(input int sel, input string what, output int lat);
        int n;
        lat = -1;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (watched(sel)) begin
                lat = cyc - acc_cyc;
                break;
            end
        end
        if (lat < 0) begin
            timeouts++;
            $display("[TIMEOUT] %0t no %s within %0d cycles", $time, what, TIMEOUT);
        end
    endtask

    // start strobes held for exactly one cycle
    task automatic issue(input logic fetch, input addr_t ia, input logic data,
                         input logic wr, input addr_t da, input word_t d, input wmask_t m);
        @(posedge clk);
        inst_start  <= fetch;
        i_addr      <= ia;
        d_cmd_start <= data;
        d_cmd_write <= wr;
        d_addr      <= da;
        wdata       <= d;
        wmask       <= m;
        @(negedge clk);
        acc_cyc = cyc;
        if (d_cmd_ready !== 1'b1) report_mismatch("d_cmd_ready at start", d_cmd_ready, 1);
        @(posedge clk);
        inst_start  <= 1'b0;
        d_cmd_start <= 1'b0;
    endtask

    task automatic write_word(input addr_t a, input word_t d, input wmask_t m);
        int lat;
        int exp_lat;
        exp_lat = (a[1:0] != 2'b00) ? 2 : 1;   // split writes take a second cycle
        issue(1'b0, '0, 1'b1, 1'b1, a, d, m);
        model_write(a, d, m);
        wait_high(SEL_READY, "d_cmd_ready after write", lat);
        if (lat != exp_lat) report_mismatch("write ready latency", lat, exp_lat);
    endtask

    task automatic read_check(input addr_t a);
        int lat;
        int exp_lat;
        exp_lat = (a[1:0] != 2'b00) ? 2 : 1;
        issue(1'b0, '0, 1'b1, 1'b0, a, '0, '0);
        wait_high(SEL_RDATA, "rdata_valid", lat);
        if (lat != exp_lat) report_mismatch("rdata_valid latency", lat, exp_lat);
        if (rdata !== model_read(a)) report_mismatch("rdata", rdata, model_read(a));
    endtask

    task automatic aligned_write_read();
        int w;
        for (w = 0; w < REGION; w++) write_word(addr_t'(4 * w), next_rand(), '1);
        for (w = 0; w < REGION; w++) read_check(addr_t'(4 * w));
    endtask

    task automatic masked_misaligned_access();
        int    off;
        addr_t a;
        write_word(addr_t'(4 * 8), next_rand(), 32'h00ff_f00f);
        read_check(addr_t'(4 * 8));
        for (off = 1; off < 4; off++) begin
            a = addr_t'(4 * (16 + 2 * off) + off);
            write_word(a, next_rand(), '1);
            read_check(a);
            write_word(a, next_rand(), next_rand());   // random mask
            read_check(a);
            read_check(a - off);                       // both words it spans
            read_check(a - off + 4);
        end
    endtask

    task automatic fetch_with_data();
        int    lat;
        addr_t ia;
        addr_t da;
        ia = addr_t'(4 * 3);
        da = addr_t'(4 * 40);
        issue(1'b1, ia, 1'b1, 1'b0, da, '0, '0);
        wait_high(SEL_INST, "inst_valid", lat);
        if (lat != 1) report_mismatch("inst_valid latency", lat, 1);
        if (inst !== model_read(ia)) report_mismatch("inst", inst, model_read(ia));
        if (d_cmd_ready !== 1'b0) report_mismatch("d_cmd_ready", d_cmd_ready, 0);
        wait_high(SEL_RDATA, "rdata_valid", lat);
        if (lat != 2) report_mismatch("rdata_valid latency", lat, 2);
        if (rdata !== model_read(da)) report_mismatch("rdata", rdata, model_read(da));
        if (d_cmd_ready !== 1'b0) report_mismatch("d_cmd_ready", d_cmd_ready, 0);
    endtask

    task automatic output_hold();
        word_t held_inst;
        word_t held_rdata;
        int    n;
        int    lat;
        held_inst  = inst;
        held_rdata = rdata;
        write_word(addr_t'(4 * 50), next_rand(), '1);
        write_word(addr_t'(4 * 51 + 2), next_rand(), '1);
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            if (inst !== held_inst) report_mismatch("inst", inst, held_inst);
            if (rdata !== held_rdata) report_mismatch("rdata", rdata, held_rdata);
        end
        read_check(addr_t'(4 * 50));
        if (inst !== held_inst) report_mismatch("inst", inst, held_inst);
        held_rdata = rdata;
        issue(1'b1, addr_t'(4 * 5), 1'b0, 1'b0, '0, '0, '0);   // fetch only
        wait_high(SEL_INST, "inst_valid", lat);
        @(negedge clk);
        if (rdata !== held_rdata) report_mismatch("rdata", rdata, held_rdata);
        if (inst !== model_read(addr_t'(4 * 5))) begin
            report_mismatch("inst", inst, model_read(addr_t'(4 * 5)));
        end
    endtask

    task automatic tx_queue_traffic();
        txq_byte_t sent [$];
        txq_byte_t b;
        int        n;
        int        lat;
        for (n = 0; n < `TXQ_DEPTH + 3; n++) begin
            b = txq_byte_t'(next_rand());
            if (n < `TXQ_DEPTH) sent.push_back(b);   // the rest overflow
            issue(1'b0, '0, 1'b1, 1'b1, `MMIO_TXQ_ADDR, {24'd0, b}, '1);
            wait_high(SEL_READY, "d_cmd_ready after queue write", lat);
            if (lat != 1) report_mismatch("queue write ready latency", lat, 1);
        end
        issue(1'b0, '0, 1'b1, 1'b0, `MMIO_TXQ_ADDR, '0, '0);
        wait_high(SEL_RDATA, "rdata_valid for queue count", lat);
        if (lat != 1) report_mismatch("queue read latency", lat, 1);
        if (rdata !== word_t'(`TXQ_DEPTH)) report_mismatch("queue count", rdata, `TXQ_DEPTH);
        if (txq_empty !== 1'b0) report_mismatch("txq_empty", txq_empty, 0);
        read_check(addr_t'(0));   // word that aliases the queue address
        while (sent.size() > 0) begin
            @(negedge clk);
            if (txq_data !== sent[0]) report_mismatch("txq_data", txq_data, sent[0]);
            void'(sent.pop_front());
            @(posedge clk);
            txq_pop <= 1'b1;
            @(posedge clk);
            txq_pop <= 1'b0;
        end
        @(negedge clk);
        if (txq_empty !== 1'b1) report_mismatch("txq_empty", txq_empty, 1);
    endtask

    task automatic halt_and_resume();
        int    n;
        int    lat;
        addr_t ia;
        addr_t da;
        ia = addr_t'(4 * 20);
        da = addr_t'(4 * 21);
        @(posedge clk);
        halt <= 1'b1;
        issue(1'b1, ia, 1'b1, 1'b0, da, '0, '0);
        for (n = 0; n < 5; n++) begin
            @(negedge clk);
            if (inst_valid !== 1'b0) report_mismatch("inst_valid while halted", inst_valid, 0);
            if (rdata_valid !== 1'b0) report_mismatch("rdata_valid while halted", rdata_valid, 0);
        end
        @(posedge clk);
        halt <= 1'b0;
        wait_high(SEL_INST, "inst_valid after halt", lat);
        if (inst !== model_read(ia)) report_mismatch("inst", inst, model_read(ia));
        wait_high(SEL_RDATA, "rdata_valid after halt", lat);
        if (rdata !== model_read(da)) report_mismatch("rdata", rdata, model_read(da));
    endtask

    initial begin
        arst_n      = 1'b0;
        halt        = 1'b0;
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        txq_pop     = 1'b0;
        rng_state   = 32'h82fc48de;
        errors      = 0;
        timeouts    = 0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (inst !== '1) report_mismatch("inst after reset", inst, '1);
        if (rdata !== '1) report_mismatch("rdata after reset", rdata, '1);
        if (inst_ready !== 1'b1) report_mismatch("inst_ready after reset", inst_ready, 1);
        aligned_write_read();
        masked_misaligned_access();
        fetch_with_data();
        output_hold();
        tx_queue_traffic();
        halt_and_resume();
        assert_fails = u_mem_subsys_top.u_arbiter.u_arb_props.fails
                     + u_mem_subsys_top.u_array.u_array_props.fails;
        $display("errors %0d timeouts %0d assertion failures %0d",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/mem_bus_pkg.sv
common/mmio_pkg.sv
mem_if/mem_arbiter.sv
mem_if/mem_access_ctrl.sv
mem_if/mem_array.sv
src/tx_queue.sv
src/mem_subsys_top.sv
verif/mem_subsys_properties.sv
verif/mem_subsys_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module mem_subsys_tb -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
